//--- hdl/rdm_buffer_layout.sv
// Lays out each user's region after a slot start
// Region size is E1 rounded up to whole rows of 16 REs
// i_user_cfg must be stable from the slot start until o_load
// Sum wraps silently if the regions overflow the 14-bit buffer space
// Idle after reset; the first table is built by the first slot start
`timescale 1ns/1ps
`default_nettype none

`include "rdm_macros.svh"

module rdm_buffer_layout (
	input  wire logic                        i_core_clk,
	input  wire logic                        i_rx_rstn,
	input  wire logic                        i_slot_start,
	input  wire rdm_pkg::rdm_user_cfg_arr_t  i_user_cfg,
	output rdm_pkg::rdm_start_arr_t          o_start,
	output logic                             o_load
);

	import rdm_pkg::*;

	localparam logic [3:0] LAST = `RDM_LAYOUT_LAST;
	localparam logic [3:0] IDLE = LAST + 4'd1;

	logic [3:0]               step_q;
	logic [`RDM_TOTAL_W-1:0]  sum_q;
	rdm_start_arr_t           start_q;

	rdm_user_cfg_t            cur_cfg;
	logic [`RDM_ROW_W-1:0]    rows;
	logic [`RDM_TOTAL_W-1:0]  region_sz;
	logic [`RDM_TOTAL_W-1:0]  run_sum;

	////////////////////////////////////////////////////////////////////////////
	// Step k handles user k, step 8 loads the table
	////////////////////////////////////////////////////////////////////////////
	assign cur_cfg   = i_user_cfg[step_q[2:0]];
	assign rows      = cur_cfg.e1_sz[4 +: `RDM_ROW_W] + 1'b1;
	assign region_sz = {rows, 4'b0000};
	assign run_sum   = (step_q == 4'd0) ? '0 : sum_q;   // User 0 starts at 0

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			step_q  <= IDLE;
			sum_q   <= '0;
			start_q <= '0;
		end
		else
		begin
			if (i_slot_start)
				step_q <= 4'd0;
			else if (step_q <= LAST)
				step_q <= step_q + 4'd1;   // Holds at IDLE

			if (step_q < LAST)
			begin
				start_q[step_q[2:0]] <= run_sum;
				sum_q                <= run_sum + region_sz;
			end
		end
	end

	assign o_start = start_q;
	assign o_load  = (step_q == LAST);

endmodule

`default_nettype wire

//--- hdl/rdm_input_writer.sv
// Write side of the de-rate-matching input buffer
// Buffer write follows the demux strobe by two cycles, no back-pressure
// Layout is ready 9 cycles after slot start
// Keep strobes at least 10 cycles clear of a slot start
// i_user_cfg is held stable through the slot
`timescale 1ns/1ps
`default_nettype none

`include "rdm_macros.svh"

module rdm_input_writer (
	input  wire logic                        i_core_clk,
	input  wire logic                        i_rx_rstn,
	input  wire logic                        i_slot_start,
	input  wire rdm_pkg::rdm_user_cfg_arr_t  i_user_cfg,
	input  wire rdm_pkg::rdm_re_in_t         i_re,
	output rdm_pkg::rdm_buf_write_t          o_buf_write,
	output logic [`RDM_MAX_USERS-1:0]        o_bank_flags
);

	import rdm_pkg::*;

	rdm_start_arr_t  start_tbl;
	logic            load;
	rdm_wr_req_t     wr_req;

	rdm_buffer_layout rdm_buffer_layout_inst (
		.i_core_clk   (i_core_clk),
		.i_rx_rstn    (i_rx_rstn),
		.i_slot_start (i_slot_start),
		.i_user_cfg   (i_user_cfg),
		.o_start      (start_tbl),
		.o_load       (load)
	);

	rdm_write_tracker rdm_write_tracker_inst (
		.i_core_clk   (i_core_clk),
		.i_rx_rstn    (i_rx_rstn),
		.i_slot_start (i_slot_start),
		.i_load       (load),
		.i_start      (start_tbl),
		.i_user_cfg   (i_user_cfg),
		.i_re         (i_re),
		.o_req        (wr_req),
		.o_bank_flags (o_bank_flags)
	);

	rdm_write_formatter rdm_write_formatter_inst (
		.i_core_clk  (i_core_clk),
		.i_rx_rstn   (i_rx_rstn),
		.i_req       (wr_req),
		.o_buf_write (o_buf_write)
	);

endmodule

`default_nettype wire

//--- hdl/rdm_macros.svh
// Fixed sizes for the de-rate-matching input buffer write side
// All widths are fixed here; the RTL modules carry no parameters
// Buffer positions are in RE units: low 4 bits pick the lane, the rest the row
`ifndef RDM_MACROS_SVH
`define RDM_MACROS_SVH

// Users and buffer geometry
`define RDM_MAX_USERS    8
`define RDM_LANES        16
`define RDM_LANE_W       48
`define RDM_RX_W         96

// Config field widths
`define RDM_SZ_W         16
`define RDM_E0_NUM_W     8
`define RDM_QM_W         4

// Buffer addressing
`define RDM_TOTAL_W      14
`define RDM_ROW_W        10
`define RDM_ADDR_W       11   // Bank bit plus row

// Layout sequence, one step per user then one load step
`define RDM_LAYOUT_LAST  8

`endif

//--- hdl/rdm_pkg.sv
// Types shared by the input buffer write side
// Sizes in the user config are RE counts minus one
// User index is one bit wider than needed so out-of-range users can be flagged
`default_nettype none

`include "rdm_macros.svh"

package rdm_pkg;

	typedef struct packed {
		logic [`RDM_SZ_W-1:0]     e0_sz;
		logic [`RDM_SZ_W-1:0]     e1_sz;
		logic [`RDM_E0_NUM_W-1:0] e0_num;     // Code blocks using E0
		logic [`RDM_QM_W-1:0]     qm;
		logic                     two_layer;
	} rdm_user_cfg_t;

	typedef rdm_user_cfg_t [`RDM_MAX_USERS-1:0] rdm_user_cfg_arr_t;

	// Demux strobe input
	typedef struct packed {
		logic                              strb;
		logic [$clog2(`RDM_MAX_USERS):0]   user_idx;
		logic [`RDM_RX_W-1:0]              rx;
	} rdm_re_in_t;

	// Tracker to formatter
	typedef struct packed {
		logic                     strb;
		logic                     user_ok;
		logic                     bank;
		logic [`RDM_TOTAL_W-1:0]  total;
		logic                     two_layer;
		logic [`RDM_QM_W-1:0]     qm;
		logic [`RDM_RX_W-1:0]     rx;
	} rdm_wr_req_t;

	// Buffer write port
	typedef struct packed {
		logic                               strb;
		logic [`RDM_ADDR_W-1:0]             addr;
		logic [`RDM_LANES*`RDM_LANE_W-1:0]  data;
		logic [`RDM_LANES-1:0]              wen;
	} rdm_buf_write_t;

	typedef logic [`RDM_MAX_USERS-1:0][`RDM_TOTAL_W-1:0] rdm_start_arr_t;

endpackage

`default_nettype wire

//--- hdl/rdm_write_formatter.sv
// Builds the buffer write port from a tracker request
// One layer: low 48 bits of rx on every lane, one lane enabled
// Two layers: lane pairs split rx by 6*Qm bits, one pair enabled
// Unsupported Qm with two layers writes zero data
// Out-of-range users write to the top address
`timescale 1ns/1ps
`default_nettype none

`include "rdm_macros.svh"

module rdm_write_formatter (
	input  wire logic                  i_core_clk,
	input  wire logic                  i_rx_rstn,
	input  wire rdm_pkg::rdm_wr_req_t  i_req,
	output rdm_pkg::rdm_buf_write_t    o_buf_write
);

	logic [`RDM_LANE_W-1:0]             lane_lo;
	logic [`RDM_LANE_W-1:0]             lane_hi;
	logic [`RDM_LANES*`RDM_LANE_W-1:0]  data_nxt;
	logic [`RDM_LANES-1:0]              wen_nxt;
	logic [`RDM_ADDR_W-1:0]             addr_nxt;
	logic [2:0]                         pair_sel;

	////////////////////////////////////////////////////////////////////////////
	// Lane data
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		lane_lo = '0;
		lane_hi = '0;
		case (i_req.qm)
			4'd1:
			begin
				lane_lo[5:0] = i_req.rx[5:0];
				lane_hi[5:0] = i_req.rx[11:6];
			end
			4'd2:
			begin
				lane_lo[11:0] = i_req.rx[11:0];
				lane_hi[11:0] = i_req.rx[23:12];
			end
			4'd4:
			begin
				lane_lo[23:0] = i_req.rx[23:0];
				lane_hi[23:0] = i_req.rx[47:24];
			end
			4'd6:
			begin
				lane_lo[35:0] = i_req.rx[35:0];
				lane_hi[35:0] = i_req.rx[71:36];
			end
			4'd8:
			begin
				lane_lo = i_req.rx[47:0];
				lane_hi = i_req.rx[95:48];
			end
			default:
			begin
				lane_lo = '0;   // Unsupported Qm
				lane_hi = '0;
			end
		endcase
	end

	assign data_nxt = i_req.two_layer ? {(`RDM_LANES/2){lane_hi, lane_lo}}
	                                  : {`RDM_LANES{i_req.rx[`RDM_LANE_W-1:0]}};

	// Lane enables, one-hot or even/odd pair
	assign pair_sel = i_req.total[3:1];

	always_comb
	begin
		wen_nxt = '0;
		if (i_req.two_layer)
		begin
			wen_nxt[{pair_sel, 1'b0}] = 1'b1;
			wen_nxt[{pair_sel, 1'b1}] = 1'b1;
		end
		else
			wen_nxt[i_req.total[3:0]] = 1'b1;
	end

	assign addr_nxt = i_req.user_ok ? {i_req.bank, i_req.total[`RDM_TOTAL_W-1:4]} : '1;

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
			o_buf_write <= '0;
		else
		begin
			o_buf_write.strb <= i_req.strb;
			o_buf_write.addr <= addr_nxt;
			o_buf_write.data <= data_nxt;
			o_buf_write.wen  <= wen_nxt;
		end
	end

endmodule

`default_nettype wire

//--- hdl/rdm_write_tracker.sv
// Per-user write position, code block count and ping-pong bank
// Positions load from the layout table on i_load
// Slot start clears RE and block counters but keeps the bank bits
// Strobes must not arrive within 10 cycles of a slot start
// Request carries the bank and position from before the update
`timescale 1ns/1ps
`default_nettype none

`include "rdm_macros.svh"

module rdm_write_tracker (
	input  wire logic                        i_core_clk,
	input  wire logic                        i_rx_rstn,
	input  wire logic                        i_slot_start,
	input  wire logic                        i_load,
	input  wire rdm_pkg::rdm_start_arr_t     i_start,
	input  wire rdm_pkg::rdm_user_cfg_arr_t  i_user_cfg,
	input  wire rdm_pkg::rdm_re_in_t         i_re,
	output rdm_pkg::rdm_wr_req_t             o_req,
	output logic [`RDM_MAX_USERS-1:0]        o_bank_flags
);

	import rdm_pkg::*;

	logic [`RDM_MAX_USERS-1:0][`RDM_SZ_W-1:0]      re_cnt_q;
	logic [`RDM_MAX_USERS-1:0][`RDM_E0_NUM_W-1:0]  cb_cnt_q;
	rdm_start_arr_t                                pos_q;
	logic [`RDM_MAX_USERS-1:0]                     bank_q;
	rdm_wr_req_t                                   req_q;

	logic [$clog2(`RDM_MAX_USERS)-1:0]  idx;
	logic                               user_ok;
	logic                               hit;
	rdm_user_cfg_t                      cfg;
	logic [`RDM_SZ_W-1:0]               step;
	logic [`RDM_SZ_W-1:0]               limit;
	logic                               in_blk;
	rdm_wr_req_t                        req_nxt;

	assign idx     = i_re.user_idx[$clog2(`RDM_MAX_USERS)-1:0];
	assign user_ok = (i_re.user_idx < `RDM_MAX_USERS);
	assign hit     = i_re.strb && user_ok;
	assign cfg     = i_user_cfg[idx];

	// 1 for one layer, 2 for two layers
	assign step = {{(`RDM_SZ_W-2){1'b0}}, cfg.two_layer, ~cfg.two_layer};

	// E0 size until e0_num blocks are done, E1 after
	assign limit  = (cb_cnt_q[idx] < cfg.e0_num) ? cfg.e0_sz : cfg.e1_sz;
	assign in_blk = (re_cnt_q[idx] < limit);

	always_comb
	begin
		req_nxt      = '0;
		req_nxt.strb = i_re.strb;
		req_nxt.rx   = i_re.rx;
		if (user_ok)
		begin
			req_nxt.user_ok   = 1'b1;
			req_nxt.bank      = bank_q[idx];
			req_nxt.total     = pos_q[idx];
			req_nxt.two_layer = cfg.two_layer;
			req_nxt.qm        = cfg.qm;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Counters and positions
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			re_cnt_q <= '0;
			cb_cnt_q <= '0;
			bank_q   <= '0;
			pos_q    <= '0;
		end
		else
		begin
			if (i_slot_start)
			begin
				re_cnt_q <= '0;
				cb_cnt_q <= '0;
			end
			else if (hit)
			begin
				if (in_blk)
					re_cnt_q[idx] <= re_cnt_q[idx] + step;
				else
				begin
					// End of code block, switch bank
					re_cnt_q[idx] <= '0;
					bank_q[idx]   <= ~bank_q[idx];
					cb_cnt_q[idx] <= cb_cnt_q[idx] + 1'b1;
				end
			end

			if (i_load)
				pos_q <= i_start;
			else if (hit)
			begin
				if (in_blk)
					pos_q[idx] <= pos_q[idx] + step[`RDM_TOTAL_W-1:0];
				else
					pos_q[idx] <= i_start[idx];   // Back to region start
			end
		end
	end

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
			req_q <= '0;
		else
			req_q <= req_nxt;
	end

	assign o_req        = req_q;
	assign o_bank_flags = bank_q;

endmodule

`default_nettype wire

//--- rdm_input_writer.f
+incdir+hdl
+incdir+verif
hdl/rdm_pkg.sv
hdl/rdm_buffer_layout.sv
hdl/rdm_write_tracker.sv
hdl/rdm_write_formatter.sv
hdl/rdm_input_writer.sv
verif/rdm_input_writer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the input writer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module rdm_input_writer_tb \
	-f rdm_input_writer.f -Mdir obj_dir > sim.log 2>&1 \
	&& ./obj_dir/Vrdm_input_writer_tb >> sim.log 2>&1 \
	|| echo "build or run error" >> sim.log
cat sim.log
grep -qx ">>> PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- verif/rdm_input_writer_checks.svh
// Compare tasks and counters for the input writer testbench
// Included inside the testbench module after the rdm_pkg import
// Every compare bumps the check count, every mismatch the error count
`ifndef RDM_INPUT_WRITER_CHECKS_SVH
`define RDM_INPUT_WRITER_CHECKS_SVH

int chk_cnt = 0;
int err_cnt = 0;

// One buffer write against the model
task automatic check_write(input string name, input rdm_buf_write_t exp_w,
                           input rdm_buf_write_t act_w);
	chk_cnt++;
	if (exp_w !== act_w)
	begin
		err_cnt++;
		$display("ERR %s exp addr=%h wen=%h data=%h act addr=%h wen=%h data=%h",
		         name, exp_w.addr, exp_w.wen, exp_w.data,
		         act_w.addr, act_w.wen, act_w.data);
	end
endtask

// Ping-pong flags of all users
task automatic check_banks(input string name, input logic [`RDM_MAX_USERS-1:0] exp_b,
                           input logic [`RDM_MAX_USERS-1:0] act_b);
	chk_cnt++;
	if (exp_b !== act_b)
	begin
		err_cnt++;
		$display("ERR %s exp banks=%b act banks=%b", name, exp_b, act_b);
	end
endtask

// Failures that are not a value mismatch
task automatic report_problem(input string msg);
	err_cnt++;
	$display("%s", msg);
endtask

`endif

//--- verif/rdm_input_writer_tb.sv
// Random stimulus against a behavioral model of layout, tracker and formatter
// Expected writes are due three negedges after the drive edge (two cycles)
// Strobes are kept 12 cycles clear of each slot start
`timescale 1ns/1ps
`default_nettype none

`include "rdm_macros.svh"

module rdm_input_writer_tb;

	import rdm_pkg::*;

	`include "rdm_input_writer_checks.svh"

	logic                         i_core_clk;
	logic                         i_rx_rstn;
	logic                         i_slot_start;
	rdm_user_cfg_arr_t            i_user_cfg;
	rdm_re_in_t                   i_re;
	rdm_buf_write_t               o_buf_write;
	logic [`RDM_MAX_USERS-1:0]    o_bank_flags;

	// Model state
	logic [`RDM_TOTAL_W-1:0]   m_start [`RDM_MAX_USERS];
	logic [`RDM_TOTAL_W-1:0]   m_pos [`RDM_MAX_USERS];
	logic [`RDM_SZ_W-1:0]      m_re [`RDM_MAX_USERS];
	logic [`RDM_E0_NUM_W-1:0]  m_cb [`RDM_MAX_USERS];
	logic [`RDM_MAX_USERS-1:0] m_bank;

	rdm_buf_write_t  exp_q [$];
	int              due_q [$];
	int              neg_cnt = 0;
	int              qm_list [6] = '{1, 2, 4, 6, 8, 3};
	string           cur_test = "reset";
	int              test_chk;
	int              test_err;

	rdm_input_writer rdm_input_writer_inst (
		.i_core_clk   (i_core_clk),
		.i_rx_rstn    (i_rx_rstn),
		.i_slot_start (i_slot_start),
		.i_user_cfg   (i_user_cfg),
		.i_re         (i_re),
		.o_buf_write  (o_buf_write),
		.o_bank_flags (o_bank_flags)
	);

	always #50 i_core_clk = ~i_core_clk;

	////////////////////////////////////////////////////////////////////////////
	// Model
	////////////////////////////////////////////////////////////////////////////
	task automatic model_write(input int u, input logic [95:0] rx, output rdm_buf_write_t w);
		rdm_user_cfg_t  c;
		logic [95:0]    mask;
		logic [47:0]    lo;
		logic [47:0]    hi;
		logic [15:0]    step;
		logic [15:0]    limit;
		int             p;
		w      = '0;
		w.strb = 1'b1;
		for (int l = 0; l < `RDM_LANES; l++)
			w.data[l*`RDM_LANE_W +: `RDM_LANE_W] = rx[47:0];
		if (u >= `RDM_MAX_USERS)
		begin
			w.addr   = '1;   // Bad user, no state change
			w.wen[0] = 1'b1;
			return;
		end
		c      = i_user_cfg[u];
		w.addr = {m_bank[u], m_pos[u][13:4]};
		if (!c.two_layer)
		begin
			w.wen[m_pos[u][3:0]] = 1'b1;
			step = 16'd1;
		end
		else
		begin
			lo = '0;
			hi = '0;
			if (c.qm inside {4'd1, 4'd2, 4'd4, 4'd6, 4'd8})
			begin
				mask = (96'd1 << (6 * c.qm)) - 96'd1;
				lo   = 48'(rx & mask);
				hi   = 48'((rx >> (6 * c.qm)) & mask);
			end
			for (int l = 0; l < `RDM_LANES; l++)
				w.data[l*`RDM_LANE_W +: `RDM_LANE_W] = l[0] ? hi : lo;
			p = int'(m_pos[u][3:1]);
			w.wen[2*p]   = 1'b1;
			w.wen[2*p+1] = 1'b1;
			step = 16'd2;
		end
		limit = (m_cb[u] < c.e0_num) ? c.e0_sz : c.e1_sz;
		if (m_re[u] < limit)
		begin
			m_re[u]  = m_re[u] + step;
			m_pos[u] = m_pos[u] + step[13:0];
		end
		else
		begin
			m_re[u]   = '0;
			m_pos[u]  = m_start[u];
			m_bank[u] = ~m_bank[u];
			m_cb[u]   = m_cb[u] + 8'd1;
		end
	endtask

	function automatic logic [95:0] rand_rx();
		return {$urandom(), $urandom(), $urandom()};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	task automatic send(input int u, input logic [95:0] rx);
		rdm_buf_write_t w;
		@(posedge i_core_clk);
		i_re.strb     <= 1'b1;
		i_re.user_idx <= 4'(u);
		i_re.rx       <= rx;
		model_write(u, rx, w);
		exp_q.push_back(w);
		due_q.push_back(neg_cnt + 3);
	endtask

	task automatic drain();
		int t;
		t = 0;
		while (exp_q.size() > 0 && t < 20)
		begin
			@(posedge i_core_clk);
			i_re.strb <= 1'b0;
			t++;
		end
		if (exp_q.size() > 0)
		begin
			report_problem($sformatf("Timeout: expected writes never appeared in test %s",
			                         cur_test));
			exp_q.delete();
			due_q.delete();
		end
	endtask

	// qm < 0 picks a random qm per user
	task automatic new_cfg(input int qm);
		rdm_user_cfg_arr_t c;
		for (int u = 0; u < `RDM_MAX_USERS; u++)
		begin
			c[u].e0_sz     = 16'($urandom() % 40);
			c[u].e1_sz     = 16'($urandom() % 40);
			c[u].e0_num    = 8'($urandom() % 4);
			c[u].qm        = 4'((qm < 0) ? qm_list[$urandom() % 6] : qm);
			c[u].two_layer = 1'($urandom() % 2);
		end
		@(posedge i_core_clk);
		i_user_cfg <= c;
	endtask

	task automatic start_slot();
		logic [13:0] sum;
		@(posedge i_core_clk);
		i_slot_start <= 1'b1;
		@(posedge i_core_clk);
		i_slot_start <= 1'b0;
		for (int t = 0; t < 12; t++)
			@(posedge i_core_clk);
		sum = '0;
		for (int u = 0; u < `RDM_MAX_USERS; u++)
		begin
			m_start[u] = sum;
			m_pos[u]   = sum;
			m_re[u]    = '0;
			m_cb[u]    = '0;
			sum = sum + 14'((i_user_cfg[u].e1_sz / 16 + 1) * 16);   // Whole rows of 16
		end
	endtask

	task automatic test_done();
		$display("test %s done: %0d checks, %0d errors", cur_test,
		         chk_cnt - test_chk, err_cnt - test_err);
		test_chk = chk_cnt;
		test_err = err_cnt;
	endtask

	// Output monitor, sampled mid-cycle
	always @(negedge i_core_clk)
	begin
		neg_cnt++;
		if (due_q.size() > 0 && due_q[0] == neg_cnt)
		begin
			if (o_buf_write.strb)
				check_write(cur_test, exp_q[0], o_buf_write);
			else
				report_problem($sformatf("Missing buffer write in test %s", cur_test));
			void'(exp_q.pop_front());
			void'(due_q.pop_front());
		end
		else if (i_rx_rstn && o_buf_write.strb)
			report_problem($sformatf("Unexpected buffer write in test %s", cur_test));
	end

	initial
	begin
		void'($urandom(85606));
		i_core_clk   = 1'b0;
		i_rx_rstn    = 1'b0;
		i_slot_start = 1'b0;
		i_user_cfg   = '0;
		i_re         = '0;
		m_bank       = '0;
		test_chk     = 0;
		test_err     = 0;
		for (int u = 0; u < `RDM_MAX_USERS; u++)
		begin
			m_start[u] = '0;
			m_pos[u]   = '0;
			m_re[u]    = '0;
			m_cb[u]    = '0;
		end
		repeat (3) @(posedge i_core_clk);
		i_rx_rstn <= 1'b1;

		@(negedge i_core_clk);
		if (o_buf_write.strb !== 1'b0)
			report_problem("Write strobe is high after reset");
		check_banks(cur_test, 8'h00, o_bank_flags);
		send(0, rand_rx());
		send(1, rand_rx());
		drain();
		test_done();

		cur_test = "layout";
		new_cfg(-1);
		start_slot();
		for (int u = 0; u < `RDM_MAX_USERS; u++)
			send(u, rand_rx());
		for (int n = 0; n < 40; n++)
			send($urandom() % 8, rand_rx());
		drain();
		check_banks(cur_test, m_bank, o_bank_flags);
		test_done();

		cur_test = "wrap";
		for (int n = 0; n < 400; n++)
			send($urandom() % 8, rand_rx());
		drain();
		check_banks(cur_test, m_bank, o_bank_flags);
		test_done();

		cur_test = "data";
		foreach (qm_list[i])
		begin
			new_cfg(qm_list[i]);
			start_slot();
			for (int n = 0; n < 30; n++)
				send($urandom() % 8, rand_rx());
			drain();
		end
		test_done();

		cur_test = "restart";
		new_cfg(-1);
		start_slot();
		@(negedge i_core_clk);
		check_banks(cur_test, m_bank, o_bank_flags);   // Slot start keeps the banks
		for (int n = 0; n < 60; n++)
			send($urandom() % 9, rand_rx());
		send(8, rand_rx());
		drain();
		check_banks(cur_test, m_bank, o_bank_flags);
		test_done();

		$display("total: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
